// ==== Makefile ====
# Verilator build and run for the rename stage testbench

VERILATOR ?= verilator
TOP ?= rename_tb
FILELIST ?= tb.f
OBJ_DIR ?= obj_dir
LOG ?= sim.log
PASS_TEXT ?= Simulation completed successfully
VFLAGS ?= --binary --timing -j 0
LINT_FLAGS ?= --lint-only -Wall --timing

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR) -o V$(TOP)

run: build
	./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "$(PASS_TEXT)" $(LOG); then \
		echo "PASS"; \
	else \
		echo "FAIL, see $(LOG)"; \
		exit 1; \
	fi

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== bench/rename_checker.sv ====
// rename stage scoreboard
// own copy of the speculative map, retirement map and free bitmap, checked every cycle
`include "rename_defines.svh"

module rename_checker (
	input logic clock,
	input logic reset,
	input logic mispredict,
	input rename_pkg::rename_req_t req1,
	input rename_pkg::rename_req_t req2,
	input rename_pkg::commit_t commit1,
	input rename_pkg::commit_t commit2,
	input rename_pkg::rename_res_t res1,
	input rename_pkg::rename_res_t res2,
	output int error_count,
	output int check_count
);
	import rename_pkg::*;

	logic [`PRF_W-1:0] map_m [`ARF_SIZE]; // speculative map
	logic [`PRF_W-1:0] rrat_m [`ARF_SIZE]; // committed map
	bit free_m [`PRF_SIZE]; // 1 = free
	rename_req_t held1, held2; // what the input register holds
	rename_res_t exp1, exp2; // what the output register should hold
	int cycle;

	// lowest free register other than skip, -1 when the pool is dry
	function automatic int lowest_free(input int skip);
		for (int i = 0; i < `PRF_SIZE; i++) begin
			if (free_m[i] && i != skip) return i;
		end
		return -1;
	endfunction

	// operand lookup, immediates give 0, older slot's new dest wins
	function automatic logic [`PRF_W-1:0] source(input logic imm, input logic [`ARF_W-1:0] arf,
		input logic fwd, input logic [`ARF_W-1:0] fwd_arf, input logic [`PRF_W-1:0] fwd_prf);
		if (imm) return '0;
		if (fwd && fwd_arf == arf) return fwd_prf; // same-pair bypass
		return map_m[arf];
	endfunction

	task automatic retire(input commit_t c);
		if (c.valid) begin
			free_m[rrat_m[c.arf]] = 1'b1; // old mapping released
			rrat_m[c.arf] = c.prf;
		end
	endtask

	task automatic recover();
		for (int i = 0; i < `PRF_SIZE; i++) begin
			free_m[i] = 1'b1;
		end
		for (int a = 0; a < `ARF_SIZE; a++) begin
			map_m[a] = rrat_m[a];
			free_m[rrat_m[a]] = 1'b0; // held by committed state
		end
	endtask

	task automatic reset_model();
		for (int a = 0; a < `ARF_SIZE; a++) begin
			map_m[a] = `PRF_W'(a);
			rrat_m[a] = `PRF_W'(a);
		end
		for (int i = 0; i < `PRF_SIZE; i++) begin
			free_m[i] = (i >= `ARF_SIZE);
		end
		held1 = '0;
		held2 = '0;
		exp1 = '0;
		exp2 = '0;
		cycle = 0;
	endtask

	////////////////////////////////////////////////////
	// one clock edge of the model
	////////////////////////////////////////////////////
	task automatic step();
		rename_res_t r1, r2;
		logic [`PRF_W-1:0] d1, d2;
		bit ren1, ren2;
		int g;
		r1 = '0;
		r2 = '0;
		d1 = '0;
		d2 = '0;
		ren1 = 1'b0;
		ren2 = 1'b0;
		if (held1.enable) begin
			g = lowest_free(-1);
			if (!held1.dest_rename) begin
				r1.valid = 1'b1; // passes without a dest
			end else if (g >= 0) begin
				r1.valid = 1'b1;
				ren1 = 1'b1;
				d1 = `PRF_W'(g);
			end else begin
				r1.halt = 1'b1;
			end
		end
		if (held2.enable) begin
			g = ren1 ? lowest_free(int'(d1)) : lowest_free(-1); // next lowest after slot 1
			if (r1.halt) begin
				r2.halt = 1'b1; // in-order dispatch
			end else if (!held2.dest_rename) begin
				r2.valid = 1'b1;
			end else if (g >= 0) begin
				r2.valid = 1'b1;
				ren2 = 1'b1;
				d2 = `PRF_W'(g);
			end else begin
				r2.halt = 1'b1;
			end
		end
		if (r1.valid) begin
			r1.opa_prf = source(held1.opa_imm, held1.opa_arf, 1'b0, '0, '0);
			r1.opb_prf = source(held1.opb_imm, held1.opb_arf, 1'b0, '0, '0);
			r1.dest_prf = d1;
			r1.opa_imm = held1.opa_imm;
			r1.opb_imm = held1.opb_imm;
		end
		if (r2.valid) begin
			r2.opa_prf = source(held2.opa_imm, held2.opa_arf, ren1, held1.dest_arf, d1);
			r2.opb_prf = source(held2.opb_imm, held2.opb_arf, ren1, held1.dest_arf, d1);
			r2.dest_prf = d2;
			r2.opa_imm = held2.opa_imm;
			r2.opb_imm = held2.opb_imm;
		end
		if (ren1) begin
			map_m[held1.dest_arf] = d1;
			free_m[d1] = 1'b0;
		end
		if (ren2) begin
			map_m[held2.dest_arf] = d2; // younger write last
			free_m[d2] = 1'b0;
		end
		retire(commit1);
		retire(commit2);
		if (mispredict) recover();
		held1 = mispredict ? '0 : req1; // wrong-path pair dropped
		held2 = mispredict ? '0 : req2;
		exp1 = r1;
		exp2 = r2;
		cycle++;
	endtask

	always @(posedge clock) begin
		if (reset) reset_model();
		else step();
	end

	////////////////////////////////////////////////////
	// comparison, half a cycle after the outputs settle
	////////////////////////////////////////////////////
	task automatic compare(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		check_count++;
		if (expected !== actual) begin
			error_count++;
			$display("CHECK FAILED %s at cycle %0d: expected %0d, actual %0d",
				name, cycle, expected, actual);
		end
	endtask

	// idle and halted slots must show zero operands as well
	task automatic compare_slot(input int slot, input rename_res_t e, input rename_res_t a);
		compare($sformatf("slot%0d valid", slot), 32'(e.valid), 32'(a.valid));
		compare($sformatf("slot%0d halt", slot), 32'(e.halt), 32'(a.halt));
		compare($sformatf("slot%0d dest_prf", slot), 32'(e.dest_prf), 32'(a.dest_prf));
		compare($sformatf("slot%0d opa_prf", slot), 32'(e.opa_prf), 32'(a.opa_prf));
		compare($sformatf("slot%0d opb_prf", slot), 32'(e.opb_prf), 32'(a.opb_prf));
		compare($sformatf("slot%0d opa_imm", slot), 32'(e.opa_imm), 32'(a.opa_imm));
		compare($sformatf("slot%0d opb_imm", slot), 32'(e.opb_imm), 32'(a.opb_imm));
	endtask

	always @(negedge clock) begin
		if (reset) begin
			error_count = 0;
			check_count = 0;
		end else begin
			compare_slot(1, exp1, res1);
			compare_slot(2, exp2, res2);
		end
	end

endmodule

// ==== bench/rename_tb.sv ====
// rename stage testbench
// seeded random pairs, in-order commits of tracked renames, mispredict pulses
`include "rename_defines.svh"

module rename_tb;
	import rename_pkg::*;

	localparam int num_cycles = 2000;
	localparam int max_cycles = num_cycles + 50; // stimulus plus drain margin

	logic clock;
	logic reset;
	logic mispredict;
	rename_req_t req1, req2;
	commit_t commit1, commit2;
	wire rename_res_t res1, res2;
	rename_req_t sent1 [2]; // pair driven one and two cycles back
	rename_req_t sent2 [2];
	commit_t inflight [$]; // accepted renames, oldest first
	int seed;
	int cycle_count = 0;
	int error_count, check_count;

	rename_top dut0 (
		.clock(clock), .reset(reset),
		.enable1(req1.enable), .opa_arf1(req1.opa_arf), .opb_arf1(req1.opb_arf),
		.dest_arf1(req1.dest_arf), .dest_rename1(req1.dest_rename),
		.opa_imm1(req1.opa_imm), .opb_imm1(req1.opb_imm),
		.enable2(req2.enable), .opa_arf2(req2.opa_arf), .opb_arf2(req2.opb_arf),
		.dest_arf2(req2.dest_arf), .dest_rename2(req2.dest_rename),
		.opa_imm2(req2.opa_imm), .opb_imm2(req2.opb_imm),
		.mispredict(mispredict),
		.commit_valid1(commit1.valid), .commit_arf1(commit1.arf), .commit_prf1(commit1.prf),
		.commit_valid2(commit2.valid), .commit_arf2(commit2.arf), .commit_prf2(commit2.prf),
		.valid1(res1.valid), .halt1(res1.halt), .opa_prf1(res1.opa_prf),
		.opb_prf1(res1.opb_prf), .dest_prf1(res1.dest_prf),
		.opa_imm_out1(res1.opa_imm), .opb_imm_out1(res1.opb_imm),
		.valid2(res2.valid), .halt2(res2.halt), .opa_prf2(res2.opa_prf),
		.opb_prf2(res2.opb_prf), .dest_prf2(res2.dest_prf),
		.opa_imm_out2(res2.opa_imm), .opb_imm_out2(res2.opb_imm)
	);

	rename_checker chk0 (
		.clock(clock), .reset(reset), .mispredict(mispredict),
		.req1(req1), .req2(req2), .commit1(commit1), .commit2(commit2),
		.res1(res1), .res2(res2),
		.error_count(error_count), .check_count(check_count)
	);

	initial begin
		clock = 1'b0;
		forever #2 clock = ~clock;
	end

	// true in num out of den draws
	function automatic bit odds(input int num, input int den);
		return ($unsigned($random(seed)) % den) < num;
	endfunction

	// no commits and no mispredicts, so the pool runs dry
	function automatic bit drought(input int cyc);
		return (cyc >= 300 && cyc < 400) || (cyc >= 1300 && cyc < 1400);
	endfunction

	task automatic random_req(output rename_req_t r);
		r.enable = odds(90, 100);
		r.opa_arf = `ARF_W'($random(seed));
		r.opb_arf = `ARF_W'($random(seed));
		r.dest_arf = `ARF_W'($random(seed));
		r.dest_rename = odds(70, 100);
		r.opa_imm = odds(20, 100);
		r.opb_imm = odds(20, 100);
	endtask

	// pick up renames that left the DUT at the last edge
	task automatic track_outputs();
		if (res1.valid && sent1[1].dest_rename) begin
			inflight.push_back('{valid: 1'b1, arf: sent1[1].dest_arf, prf: res1.dest_prf});
		end
		if (res2.valid && sent2[1].dest_rename) begin
			inflight.push_back('{valid: 1'b1, arf: sent2[1].dest_arf, prf: res2.dest_prf});
		end
		if (mispredict) inflight.delete(); // wrong path never commits
		sent1[1] = sent1[0];
		sent2[1] = sent2[0];
	endtask

	task automatic pick_commits(input int cyc);
		int n;
		commit1 = '0;
		commit2 = '0;
		n = drought(cyc) ? 0 : $unsigned($random(seed)) % 3;
		if (n > 0 && inflight.size() > 0) commit1 = inflight.pop_front();
		if (n > 1 && inflight.size() > 0) commit2 = inflight.pop_front();
	endtask

	always @(posedge clock) begin
		if (!reset) cycle_count <= cycle_count + 1;
	end

	initial begin
		wait (cycle_count >= max_cycles);
		$display("timeout: run still going after %0d cycles", max_cycles);
		$display("Simulation failed");
		$finish;
	end

	////////////////////////////////////////////////////
	// stimulus
	////////////////////////////////////////////////////
	initial begin
		seed = 63;
		reset = 1'b1;
		mispredict = 1'b0;
		req1 = '0;
		req2 = '0;
		commit1 = '0;
		commit2 = '0;
		sent1[0] = '0;
		sent1[1] = '0;
		sent2[0] = '0;
		sent2[1] = '0;
		repeat (10) @(posedge clock);
		#1;
		reset = 1'b0;
		for (int cyc = 0; cyc < num_cycles; cyc++) begin
			track_outputs();
			pick_commits(cyc);
			mispredict = !drought(cyc) && odds(1, 40);
			random_req(req1);
			random_req(req2);
			sent1[0] = req1;
			sent2[0] = req2;
			@(posedge clock);
			#1;
		end
		req1 = '0; // let the last pair drain
		req2 = '0;
		commit1 = '0;
		commit2 = '0;
		mispredict = 1'b0;
		repeat (3) @(posedge clock);
		#1;
		$display("checks: %0d, errors: %0d", check_count, error_count);
		if (error_count == 0) begin
			$display("Simulation completed successfully");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule

// ==== tb.f ====
+incdir+verilog
verilog/rename_pkg.sv
verilog/rename_if.sv
verilog/rename_stage_in.sv
verilog/map_table.sv
verilog/free_list.sv
verilog/retire_map.sv
verilog/rename_stage_out.sv
verilog/rename_top.sv
bench/rename_checker.sv
bench/rename_tb.sv

// ==== verilog/free_list.sv ====
// physical register free list
// bitmap allocator granting the two lowest free registers, rebuilt on recovery
`include "rename_defines.svh"

module free_list (
	input logic clock,
	input logic reset,
	input logic mispredict,
	input logic alloc1,
	input logic alloc2,
	input logic displaced1,
	input logic displaced2,
	input logic [`PRF_W-1:0] displaced_idx1,
	input logic [`PRF_W-1:0] displaced_idx2,
	input rename_pkg::map_t committed_next,
	output logic [`PRF_W-1:0] grant_idx1,
	output logic [`PRF_W-1:0] grant_idx2,
	output logic [1:0] free_count
);

	logic [`PRF_SIZE-1:0] free_bits; // 1 = free
	logic [`PRF_SIZE-1:0] masked; // free bits minus first grant
	logic [`PRF_SIZE-1:0] free_next;
	logic [`PRF_SIZE-1:0] rebuilt;
	logic found1, found2;

	// priority search, returns {found, index} of lowest set bit
	function automatic logic [`PRF_W:0] find_low(input logic [`PRF_SIZE-1:0] bits);
		logic [`PRF_W:0] r;
		r = '0;
		for (int i = `PRF_SIZE - 1; i >= 0; i--) begin
			if (bits[i]) r = {1'b1, `PRF_W'(i)}; // lower index overrides
		end
		return r;
	endfunction

	////////////////////////////////////////////////////
	// grants
	////////////////////////////////////////////////////
	always_comb begin
		{found1, grant_idx1} = find_low(free_bits);
		masked = free_bits;
		if (found1) masked[grant_idx1] = 1'b0;
		{found2, grant_idx2} = find_low(masked); // next lowest
		if (found2) free_count = 2'd2; // saturates
		else if (found1) free_count = 2'd1;
		else free_count = 2'd0;
	end

	////////////////////////////////////////////////////
	// bitmap update
	////////////////////////////////////////////////////
	always_comb begin
		free_next = free_bits;
		if (alloc1) free_next[grant_idx1] = 1'b0;
		if (alloc2) free_next[grant_idx2] = 1'b0;
		if (displaced1) free_next[displaced_idx1] = 1'b1; // old mapping retired
		if (displaced2) free_next[displaced_idx2] = 1'b1;
	end

	// everything the committed map does not name is free
	always_comb begin
		rebuilt = '1;
		for (int i = 0; i < `ARF_SIZE; i++) begin
			rebuilt[committed_next[i]] = 1'b0;
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			for (int i = 0; i < `PRF_SIZE; i++) begin
				free_bits[i] <= (i >= `ARF_SIZE); // low regs hold the identity map
			end
		end else if (mispredict) begin
			free_bits <= rebuilt;
		end else begin
			free_bits <= free_next;
		end
	end

endmodule

// ==== verilog/map_table.sv ====
// speculative register alias table
// two-wide source lookup with intra-pair bypass, slot accept/halt, recovery copy
`include "rename_defines.svh"

module map_table (
	input logic clock,
	input logic reset,
	input logic mispredict,
	rename_req_if.tbl req_bus,
	rename_res_if.tbl res_bus,
	input logic [`PRF_W-1:0] grant_idx1,
	input logic [`PRF_W-1:0] grant_idx2,
	input logic [1:0] free_count,
	input rename_pkg::map_t committed_next,
	output logic alloc1,
	output logic alloc2
);
	import rename_pkg::*;

	map_t rat_reg; // current speculative map
	map_t rat_next;
	rename_req_t rq1, rq2;
	slot_state_e state1, state2;
	logic en1, en2;
	logic rename1, rename2;
	logic [`PRF_W-1:0] dest1, dest2;
	logic [`PRF_W-1:0] opa1, opb1, opa2, opb2;

	// zero everything except halt unless the slot went through
	function automatic rename_res_t pack_res(
		input slot_state_e st,
		input rename_req_t rq,
		input logic [`PRF_W-1:0] opa,
		input logic [`PRF_W-1:0] opb,
		input logic [`PRF_W-1:0] dest
	);
		rename_res_t r;
		r = '0;
		r.halt = (st == SLOT_HALTED);
		if (st == SLOT_RENAMED || st == SLOT_PASSED) begin
			r.valid = 1'b1;
			r.opa_prf = opa;
			r.opb_prf = opb;
			r.dest_prf = dest;
			r.opa_imm = rq.opa_imm;
			r.opb_imm = rq.opb_imm;
		end
		return r;
	endfunction

	assign rq1 = req_bus.req1;
	assign rq2 = req_bus.req2;
	assign en1 = rq1.enable & ~req_bus.flush;
	assign en2 = rq2.enable & ~req_bus.flush;

	////////////////////////////////////////////////////
	// slot outcome
	////////////////////////////////////////////////////
	always_comb begin
		state1 = SLOT_IDLE;
		if (en1) begin
			if (!rq1.dest_rename) state1 = SLOT_PASSED;
			else if (free_count != 2'd0) state1 = SLOT_RENAMED;
			else state1 = SLOT_HALTED; // pool empty
		end
		state2 = SLOT_IDLE;
		if (en2) begin
			if (state1 == SLOT_HALTED) state2 = SLOT_HALTED; // stay in order
			else if (!rq2.dest_rename) state2 = SLOT_PASSED;
			else if (free_count > {1'b0, state1 == SLOT_RENAMED}) state2 = SLOT_RENAMED;
			else state2 = SLOT_HALTED;
		end
	end

	assign rename1 = (state1 == SLOT_RENAMED);
	assign rename2 = (state2 == SLOT_RENAMED);
	assign alloc1 = rename1 | rename2; // lowest grant taken
	assign alloc2 = rename1 & rename2; // both grants taken

	// slot 2 gets the second grant only if slot 1 used the first
	assign dest1 = rename1 ? grant_idx1 : '0;
	assign dest2 = rename2 ? (rename1 ? grant_idx2 : grant_idx1) : '0;

	////////////////////////////////////////////////////
	// source lookup and bypass
	////////////////////////////////////////////////////
	assign opa1 = rq1.opa_imm ? '0 : rat_reg[rq1.opa_arf];
	assign opb1 = rq1.opb_imm ? '0 : rat_reg[rq1.opb_arf];
	assign opa2 = rq2.opa_imm ? '0 :
		(rename1 && rq1.dest_arf == rq2.opa_arf) ? dest1 : rat_reg[rq2.opa_arf];
	assign opb2 = rq2.opb_imm ? '0 :
		(rename1 && rq1.dest_arf == rq2.opb_arf) ? dest1 : rat_reg[rq2.opb_arf];

	assign res_bus.res1 = pack_res(state1, rq1, opa1, opb1, dest1);
	assign res_bus.res2 = pack_res(state2, rq2, opa2, opb2, dest2);

	////////////////////////////////////////////////////
	// map update
	////////////////////////////////////////////////////
	always_comb begin
		rat_next = rat_reg;
		if (rename1) rat_next[rq1.dest_arf] = dest1;
		if (rename2) rat_next[rq2.dest_arf] = dest2; // younger write wins
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			for (int i = 0; i < `ARF_SIZE; i++) begin
				rat_reg[i] <= `PRF_W'(i); // identity map
			end
		end else if (mispredict) begin
			rat_reg <= committed_next; // back to committed state
		end else begin
			rat_reg <= rat_next;
		end
	end

endmodule

// ==== verilog/rename_defines.svh ====
// rename stage sizes
// register counts and index widths shared by the package and the RTL
`ifndef RENAME_DEFINES_SVH
`define RENAME_DEFINES_SVH

////////////////////////////////////////////////////
// register file sizes
////////////////////////////////////////////////////
`define ARF_SIZE 32 // architectural registers
`define PRF_SIZE 64 // physical registers

////////////////////////////////////////////////////
// index widths
////////////////////////////////////////////////////
`define ARF_W 5 // log2 of ARF_SIZE
`define PRF_W 6 // log2 of PRF_SIZE

`endif

// ==== verilog/rename_if.sv ====
// rename stage interfaces
// request pair into the map table and result pair out of it

interface rename_req_if;
	import rename_pkg::*;

	rename_req_t req1; // older slot
	rename_req_t req2; // younger slot
	logic flush; // recovery cycle, no requests held

	modport stage (
		output req1,
		output req2,
		output flush
	);

	// map table side
	modport tbl (
		input req1,
		input req2,
		input flush
	);
endinterface

interface rename_res_if;
	import rename_pkg::*;

	rename_res_t res1;
	rename_res_t res2;

	modport tbl (
		output res1,
		output res2
	);

	modport stage (
		input res1,
		input res2
	);
endinterface

// ==== verilog/rename_pkg.sv ====
// rename package
// slot request, slot result and commit types plus the slot outcome enum
`include "rename_defines.svh"

package rename_pkg;

	typedef struct packed {
		logic enable; // slot holds an instruction
		logic [`ARF_W-1:0] opa_arf;
		logic [`ARF_W-1:0] opb_arf;
		logic [`ARF_W-1:0] dest_arf;
		logic dest_rename; // needs a fresh physical reg
		logic opa_imm; // opa is an immediate, no lookup
		logic opb_imm;
	} rename_req_t;

	typedef struct packed {
		logic valid; // slot accepted this cycle
		logic halt; // slot must be presented again
		logic [`PRF_W-1:0] opa_prf;
		logic [`PRF_W-1:0] opb_prf;
		logic [`PRF_W-1:0] dest_prf; // zero when nothing renamed
		logic opa_imm;
		logic opb_imm;
	} rename_res_t;

	typedef struct packed {
		logic valid;
		logic [`ARF_W-1:0] arf;
		logic [`PRF_W-1:0] prf;
	} commit_t;

	// one physical index per architectural register
	typedef logic [`ARF_SIZE-1:0][`PRF_W-1:0] map_t;

	typedef enum logic [1:0] {
		SLOT_IDLE, // nothing presented
		SLOT_RENAMED, // accepted with new dest
		SLOT_PASSED, // accepted, no dest needed
		SLOT_HALTED // no register or earlier slot halted
	} slot_state_e;

endpackage

// ==== verilog/rename_stage_in.sv ====
// rename input register
// captures the incoming instruction pair, drops it on a mispredict

module rename_stage_in (
	input logic clock,
	input logic reset,
	input logic mispredict,
	input rename_pkg::rename_req_t req1_in,
	input rename_pkg::rename_req_t req2_in,
	rename_req_if.stage req_bus
);

	////////////////////////////////////////////////////
	// request pair
	////////////////////////////////////////////////////
	always_ff @(posedge clock) begin
		if (reset || mispredict) begin
			req_bus.req1 <= '0; // wrong path, throw away
			req_bus.req2 <= '0;
		end else begin
			req_bus.req1 <= req1_in;
			req_bus.req2 <= req2_in;
		end
	end

	////////////////////////////////////////////////////
	// recovery marker
	////////////////////////////////////////////////////
	// high for the cycle right after the recovery edge
	always_ff @(posedge clock) begin
		if (reset) begin
			req_bus.flush <= 1'b0;
		end else begin
			req_bus.flush <= mispredict;
		end
	end

endmodule

// ==== verilog/rename_stage_out.sv ====
// rename output register
// holds the renamed pair and halt flags for dispatch

module rename_stage_out (
	input logic clock,
	input logic reset,
	rename_res_if.stage res_bus,
	output rename_pkg::rename_res_t res1_out,
	output rename_pkg::rename_res_t res2_out
);

	////////////////////////////////////////////////////
	// result pair
	////////////////////////////////////////////////////
	always_ff @(posedge clock) begin
		if (reset) begin
			res1_out <= '0; // valid and halt low
			res2_out <= '0;
		end else begin
			res1_out <= res_bus.res1;
			res2_out <= res_bus.res2;
		end
	end

endmodule

// ==== verilog/rename_top.sv ====
// two-wide register rename top
// input register, map table, free list, retirement map and output register
`include "rename_defines.svh"

module rename_top (
	input logic clock,
	input logic reset,
	// slot 1
	input logic enable1,
	input logic [`ARF_W-1:0] opa_arf1,
	input logic [`ARF_W-1:0] opb_arf1,
	input logic [`ARF_W-1:0] dest_arf1,
	input logic dest_rename1,
	input logic opa_imm1,
	input logic opb_imm1,
	// slot 2
	input logic enable2,
	input logic [`ARF_W-1:0] opa_arf2,
	input logic [`ARF_W-1:0] opb_arf2,
	input logic [`ARF_W-1:0] dest_arf2,
	input logic dest_rename2,
	input logic opa_imm2,
	input logic opb_imm2,
	input logic mispredict,
	// retiring mappings
	input logic commit_valid1,
	input logic [`ARF_W-1:0] commit_arf1,
	input logic [`PRF_W-1:0] commit_prf1,
	input logic commit_valid2,
	input logic [`ARF_W-1:0] commit_arf2,
	input logic [`PRF_W-1:0] commit_prf2,
	// renamed pair
	output logic valid1,
	output logic halt1,
	output logic [`PRF_W-1:0] opa_prf1,
	output logic [`PRF_W-1:0] opb_prf1,
	output logic [`PRF_W-1:0] dest_prf1,
	output logic opa_imm_out1,
	output logic opb_imm_out1,
	output logic valid2,
	output logic halt2,
	output logic [`PRF_W-1:0] opa_prf2,
	output logic [`PRF_W-1:0] opb_prf2,
	output logic [`PRF_W-1:0] dest_prf2,
	output logic opa_imm_out2,
	output logic opb_imm_out2
);
	import rename_pkg::*;

	rename_req_t req1_in, req2_in;
	rename_res_t res1_out, res2_out;
	commit_t commit1, commit2;
	map_t committed_next; // post-commit map for recovery
	logic [`PRF_W-1:0] grant_idx1, grant_idx2;
	logic [1:0] free_count;
	logic alloc1, alloc2;
	logic displaced1, displaced2;
	logic [`PRF_W-1:0] displaced_idx1, displaced_idx2;

	rename_req_if req_bus ();
	rename_res_if res_bus ();

	////////////////////////////////////////////////////
	// pack plain ports
	////////////////////////////////////////////////////
	assign req1_in = '{enable: enable1, opa_arf: opa_arf1, opb_arf: opb_arf1,
		dest_arf: dest_arf1, dest_rename: dest_rename1,
		opa_imm: opa_imm1, opb_imm: opb_imm1};
	assign req2_in = '{enable: enable2, opa_arf: opa_arf2, opb_arf: opb_arf2,
		dest_arf: dest_arf2, dest_rename: dest_rename2,
		opa_imm: opa_imm2, opb_imm: opb_imm2};
	assign commit1 = '{valid: commit_valid1, arf: commit_arf1, prf: commit_prf1};
	assign commit2 = '{valid: commit_valid2, arf: commit_arf2, prf: commit_prf2};

	////////////////////////////////////////////////////
	// stages
	////////////////////////////////////////////////////
	rename_stage_in stage_in0 (
		.clock(clock),
		.reset(reset),
		.mispredict(mispredict),
		.req1_in(req1_in),
		.req2_in(req2_in),
		.req_bus(req_bus.stage)
	);

	map_table rat0 (
		.clock(clock),
		.reset(reset),
		.mispredict(mispredict),
		.req_bus(req_bus.tbl),
		.res_bus(res_bus.tbl),
		.grant_idx1(grant_idx1),
		.grant_idx2(grant_idx2),
		.free_count(free_count),
		.committed_next(committed_next),
		.alloc1(alloc1),
		.alloc2(alloc2)
	);

	free_list fl0 (
		.clock(clock),
		.reset(reset),
		.mispredict(mispredict),
		.alloc1(alloc1),
		.alloc2(alloc2),
		.displaced1(displaced1),
		.displaced2(displaced2),
		.displaced_idx1(displaced_idx1),
		.displaced_idx2(displaced_idx2),
		.committed_next(committed_next),
		.grant_idx1(grant_idx1),
		.grant_idx2(grant_idx2),
		.free_count(free_count)
	);

	retire_map rrat0 (
		.clock(clock),
		.reset(reset),
		.commit1(commit1),
		.commit2(commit2),
		.committed_next(committed_next),
		.displaced1(displaced1),
		.displaced2(displaced2),
		.displaced_idx1(displaced_idx1),
		.displaced_idx2(displaced_idx2)
	);

	rename_stage_out stage_out0 (
		.clock(clock),
		.reset(reset),
		.res_bus(res_bus.stage),
		.res1_out(res1_out),
		.res2_out(res2_out)
	);

	////////////////////////////////////////////////////
	// unpack to plain ports
	////////////////////////////////////////////////////
	assign valid1 = res1_out.valid;
	assign halt1 = res1_out.halt;
	assign opa_prf1 = res1_out.opa_prf;
	assign opb_prf1 = res1_out.opb_prf;
	assign dest_prf1 = res1_out.dest_prf;
	assign opa_imm_out1 = res1_out.opa_imm;
	assign opb_imm_out1 = res1_out.opb_imm;
	assign valid2 = res2_out.valid;
	assign halt2 = res2_out.halt;
	assign opa_prf2 = res2_out.opa_prf;
	assign opb_prf2 = res2_out.opb_prf;
	assign dest_prf2 = res2_out.dest_prf;
	assign opa_imm_out2 = res2_out.opa_imm;
	assign opb_imm_out2 = res2_out.opb_imm;

endmodule

// ==== verilog/retire_map.sv ====
// retirement map
// committed mappings, up to two commits a cycle, reports displaced registers
`include "rename_defines.svh"

module retire_map (
	input logic clock,
	input logic reset,
	input rename_pkg::commit_t commit1,
	input rename_pkg::commit_t commit2,
	output rename_pkg::map_t committed_next,
	output logic displaced1,
	output logic displaced2,
	output logic [`PRF_W-1:0] displaced_idx1,
	output logic [`PRF_W-1:0] displaced_idx2
);
	import rename_pkg::*;

	map_t rrat; // committed map

	////////////////////////////////////////////////////
	// commit in order, commit1 then commit2
	////////////////////////////////////////////////////
	always_comb begin
		committed_next = rrat;
		displaced1 = commit1.valid;
		displaced_idx1 = '0;
		if (commit1.valid) begin
			displaced_idx1 = committed_next[commit1.arf];
			committed_next[commit1.arf] = commit1.prf;
		end
		// sees commit1's write when both hit one arf
		displaced2 = commit2.valid;
		displaced_idx2 = '0;
		if (commit2.valid) begin
			displaced_idx2 = committed_next[commit2.arf];
			committed_next[commit2.arf] = commit2.prf;
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			for (int i = 0; i < `ARF_SIZE; i++) begin
				rrat[i] <= `PRF_W'(i);
			end
		end else begin
			rrat <= committed_next;
		end
	end

endmodule
